/* design/fpu_add_sub.sv */
// ---------------------------------------------------------------------------
// three stage single precision add/sub: align, add, normalize and round
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_add_sub
  import fpu_format_pkg::*;
  import fpu_status_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       en_i,

  input  logic       v_i,
  input  fp_word_u   a_i,
  input  fp_word_u   b_i,
  input  logic       sub_i,
  output logic       ready_o,

  output logic       v_o,
  input  logic       yumi_i,
  output fp_word_u   z_o,
  output fpu_flags_t flags_o
);

  logic stall;
  logic advance;
  logic v_1_r, v_2_r, v_3_r;

  assign stall   = v_3_r & ~yumi_i;
  assign advance = ~stall & en_i;
  assign ready_o = advance;

  // stage 1: classify, align smaller operand, pick sign
  fp_class_t a_class, b_class;

  fpu_classify u_classify_a (
    .op_i    (a_i),
    .class_o (a_class)
  );

  fpu_classify u_classify_b (
    .op_i    (b_i),
    .class_o (b_class)
  );

  logic                            exp_a_less;
  logic [`FPU_EXP_W-1:0]           larger_exp;
  logic [`FPU_EXP_W-1:0]           exp_diff;
  logic [`FPU_SIG_W-1:0]           sig_a, sig_b;
  logic [`FPU_SIG_W-1:0]           larger_sig, smaller_sig;
  logic [2*(`FPU_SIG_W+2)-1:0]     align_window;
  logic                            sticky;
  logic [`FPU_ALIGN_W-1:0]         larger_padded, smaller_aligned;
  logic                            mag_a_less;
  logic                            result_sign;
  logic                            do_sub;

  // zero operands get no hidden bit, denormals are rejected later
  assign sig_a = {|a_i.f.exp, a_i.f.man};
  assign sig_b = {|b_i.f.exp, b_i.f.man};

  assign exp_a_less  = a_i.f.exp < b_i.f.exp;
  assign larger_exp  = exp_a_less ? b_i.f.exp : a_i.f.exp;
  assign exp_diff    = exp_a_less ? (b_i.f.exp - a_i.f.exp) : (a_i.f.exp - b_i.f.exp);
  assign larger_sig  = exp_a_less ? sig_b : sig_a;
  assign smaller_sig = exp_a_less ? sig_a : sig_b;

  // upper half keeps guard and round, lower half collects shifted-out bits
  assign align_window = {smaller_sig, 2'b00, {(`FPU_SIG_W+2){1'b0}}} >> exp_diff;
  assign sticky = (exp_diff >= (`FPU_SIG_W + 2)) ? (|smaller_sig)
                                                 : (|align_window[`FPU_SIG_W+1:0]);

  assign larger_padded   = {larger_sig, 3'b000};
  assign smaller_aligned = {align_window[2*(`FPU_SIG_W+2)-1 -: `FPU_SIG_W+2], sticky};

  assign mag_a_less  = a_i.raw[`FPU_WORD_W-2:0] < b_i.raw[`FPU_WORD_W-2:0];
  assign result_sign = mag_a_less ? (b_i.f.sign ^ sub_i) : a_i.f.sign;
  assign do_sub      = sub_i ^ a_i.f.sign ^ b_i.f.sign;

  logic                    sign_1_r, do_sub_1_r;
  logic [`FPU_EXP_W-1:0]   exp_1_r;
  logic [`FPU_ALIGN_W-1:0] larger_1_r, smaller_1_r;
  fp_class_t               a_class_1_r, b_class_1_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_1_r <= 1'b0;
    end else if (advance) begin
      v_1_r <= v_i;
    end
  end

  // exponent carries one extra for the adder carry-out position
  always_ff @(posedge clk_i) begin
    if (advance & v_i) begin
      sign_1_r    <= result_sign;
      do_sub_1_r  <= do_sub;
      exp_1_r     <= larger_exp + 1'b1;
      larger_1_r  <= larger_padded;
      smaller_1_r <= smaller_aligned;
      a_class_1_r <= a_class;
      b_class_1_r <= b_class;
    end
  end

  // stage 2: order by magnitude, then add or subtract
  logic                    swap;
  logic [`FPU_ALIGN_W-1:0] big_man, little_man;
  logic [`FPU_SUM_W-1:0]   sum;

  // only possible when both exponents matched
  assign swap       = larger_1_r < smaller_1_r;
  assign big_man    = swap ? smaller_1_r : larger_1_r;
  assign little_man = swap ? larger_1_r : smaller_1_r;
  assign sum = do_sub_1_r ? ({1'b0, big_man} - {1'b0, little_man})
                          : ({1'b0, big_man} + {1'b0, little_man});

  logic                  sign_2_r, do_sub_2_r;
  logic [`FPU_EXP_W-1:0] exp_2_r;
  logic [`FPU_SUM_W-1:0] sum_2_r;
  fp_class_t             a_class_2_r, b_class_2_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_2_r <= 1'b0;
    end else if (advance) begin
      v_2_r <= v_1_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance & v_1_r) begin
      sign_2_r    <= sign_1_r;
      do_sub_2_r  <= do_sub_1_r;
      exp_2_r     <= exp_1_r;
      sum_2_r     <= sum;
      a_class_2_r <= a_class_1_r;
      b_class_2_r <= b_class_1_r;
    end
  end

  // stage 3: normalize, round, resolve special cases
  logic [`FPU_LZ_W-1:0]    lz_count;
  logic                    sum_zero;
  logic [`FPU_SUM_W-1:0]   norm;
  logic [`FPU_EXP_W-1:0]   adj_exp;
  logic                    exp_borrow;
  logic                    round_up;
  logic [`FPU_WORD_W-2:0]  rounded;
  logic                    overflow, underflow;
  fp_word_u                z_next;
  fpu_flags_t              flags_next;

  fpu_leading_zeros u_leading_zeros (
    .value_i    (sum_2_r),
    .count_o    (lz_count),
    .all_zero_o (sum_zero)
  );

  assign norm = sum_2_r << lz_count;
  assign {exp_borrow, adj_exp} = {1'b0, exp_2_r}
                               - {{(`FPU_EXP_W+1-`FPU_LZ_W){1'b0}}, lz_count};

  // nearest even: guard set and either sticky bits or odd lsb
  assign round_up = norm[3] & ((|norm[2:0]) | norm[4]);
  assign rounded  = {adj_exp, norm[`FPU_SUM_W-2 -: `FPU_MAN_W]} + round_up;

  // a mantissa carry can push the exponent into either limit
  assign overflow  = (&adj_exp) | (&rounded[`FPU_WORD_W-2 -: `FPU_EXP_W]);
  assign underflow = exp_borrow | ~|rounded[`FPU_WORD_W-2 -: `FPU_EXP_W];

  always_comb begin
    flags_next = '0;
    z_next.raw = {sign_2_r, rounded};
    if (a_class_2_r.sig_nan | b_class_2_r.sig_nan) begin
      flags_next.invalid = 1'b1;
      z_next.raw = `FPU_SNAN_RESULT(sign_2_r);
    end else if (a_class_2_r.nan | b_class_2_r.nan) begin
      z_next.raw = `FPU_QNAN;
    end else if (a_class_2_r.infty & b_class_2_r.infty & do_sub_2_r) begin
      // opposite infinities cancel
      flags_next.invalid = 1'b1;
      z_next.raw = `FPU_QNAN;
    end else if (a_class_2_r.infty | b_class_2_r.infty) begin
      z_next.raw = `FPU_INF(sign_2_r);
    end else if (a_class_2_r.denormal | b_class_2_r.denormal) begin
      flags_next.unimplemented = 1'b1;
      z_next.raw = `FPU_QNAN;
    end else if (sum_zero) begin
      // exact cancellation is +0 under round to nearest
      z_next.raw = `FPU_ZERO(sign_2_r & ~do_sub_2_r);
    end else if (underflow) begin
      flags_next.underflow = 1'b1;
      z_next.raw = `FPU_ZERO(sign_2_r);
    end else if (overflow) begin
      flags_next.overflow = 1'b1;
      z_next.raw = `FPU_INF(sign_2_r);
    end
  end

  fp_word_u   z_3_r;
  fpu_flags_t flags_3_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_3_r <= 1'b0;
    end else if (advance) begin
      v_3_r <= v_2_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance & v_2_r) begin
      z_3_r     <= z_next;
      flags_3_r <= flags_next;
    end
  end

  assign v_o     = v_3_r;
  assign z_o     = z_3_r;
  assign flags_o = flags_3_r;

endmodule

/* design/fpu_classify.sv */
// ---------------------------------------------------------------------------
// operand classifier: zero, nan, signaling nan, infinity, denormal
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_classify
  import fpu_format_pkg::*;
(
  input  fp_word_u  op_i,
  output fp_class_t class_o
);

  logic exp_ones;
  logic exp_zero;
  logic man_zero;

  assign exp_ones = &op_i.f.exp;
  assign exp_zero = ~|op_i.f.exp;
  assign man_zero = ~|op_i.f.man;

  assign class_o.zero     = exp_zero & man_zero;
  assign class_o.denormal = exp_zero & ~man_zero;
  assign class_o.infty    = exp_ones & man_zero;
  assign class_o.nan      = exp_ones & ~man_zero;

  // quiet bit clear marks a signaling nan
  assign class_o.sig_nan  = exp_ones & ~man_zero & ~op_i.f.man[`FPU_MAN_W-1];

endmodule

/* design/fpu_consts.svh */
// ---------------------------------------------------------------------------
// single precision format widths and canonical special encodings
// ---------------------------------------------------------------------------
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

`define FPU_EXP_W 8
`define FPU_MAN_W 23
`define FPU_WORD_W (`FPU_EXP_W + `FPU_MAN_W + 1)

// significand with hidden bit, aligned operand, adder result, zero count
`define FPU_SIG_W (`FPU_MAN_W + 1)
`define FPU_ALIGN_W (`FPU_MAN_W + 4)
`define FPU_SUM_W (`FPU_MAN_W + 5)
`define FPU_LZ_W 5

`define FPU_QNAN {1'b0, {`FPU_EXP_W{1'b1}}, 1'b1, {(`FPU_MAN_W-1){1'b0}}}
`define FPU_SNAN_RESULT(s) {s, {`FPU_EXP_W{1'b1}}, 1'b1, {(`FPU_MAN_W-2){1'b0}}, 1'b1}
`define FPU_INF(s) {s, {`FPU_EXP_W{1'b1}}, {`FPU_MAN_W{1'b0}}}
`define FPU_ZERO(s) {s, {(`FPU_WORD_W-1){1'b0}}}

`endif

/* design/fpu_format_pkg.sv */
// ---------------------------------------------------------------------------
// floating point word layout and operand class bits
// ---------------------------------------------------------------------------
`include "fpu_consts.svh"

package fpu_format_pkg;

  // sign, biased exponent, stored mantissa
  typedef struct packed {
    logic                  sign;
    logic [`FPU_EXP_W-1:0] exp;
    logic [`FPU_MAN_W-1:0] man;
  } fp_fields_t;

  // same word seen as raw bits or as fields
  typedef union packed {
    logic [`FPU_WORD_W-1:0] raw;
    fp_fields_t             f;
  } fp_word_u;

  // decoded operand kind
  typedef struct packed {
    logic zero;
    logic nan;
    logic sig_nan;
    logic infty;
    logic denormal;
  } fp_class_t;

endpackage

/* design/fpu_leading_zeros.sv */
// ---------------------------------------------------------------------------
// leading zero counter for the adder result, with all zero detect
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_leading_zeros (
  input  logic [`FPU_SUM_W-1:0] value_i,
  output logic [`FPU_LZ_W-1:0]  count_o,
  output logic                  all_zero_o
);

  // priority search, the highest set bit wins
  always_comb begin
    int unsigned zeros;
    zeros = 0;
    for (int i = 0; i < `FPU_SUM_W; i++) begin
      if (value_i[i]) begin
        zeros = `FPU_SUM_W - 1 - i;
      end
    end
    count_o = zeros[`FPU_LZ_W-1:0];
  end

  // count is meaningless when nothing is set
  assign all_zero_o = ~|value_i;

endmodule

/* design/fpu_status_pkg.sv */
// ---------------------------------------------------------------------------
// exception flags and configuration write types
// ---------------------------------------------------------------------------
package fpu_status_pkg;

  // per result exceptions
  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic unimplemented;
  } fpu_flags_t;

  // we loads enable, clear_flags empties the accumulator
  typedef struct packed {
    logic we;
    logic enable;
    logic clear_flags;
  } fpu_cfg_t;

endpackage

/* design/fpu_status_regs.sv */
// ---------------------------------------------------------------------------
// enable bit and sticky exception flag accumulator
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module fpu_status_regs
  import fpu_status_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  fpu_cfg_t   cfg_i,

  input  logic       v_i,
  input  logic       yumi_i,
  input  fpu_flags_t flags_i,

  output logic       en_o,
  output fpu_flags_t flags_accum_o
);

  logic       en_r;
  fpu_flags_t accum_r;

  // comes out of reset running
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_r <= 1'b1;
    end else if (cfg_i.we) begin
      en_r <= cfg_i.enable;
    end
  end

  // only results the sink actually took are counted
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      accum_r <= '0;
    end else if (cfg_i.clear_flags) begin
      accum_r <= '0;
    end else if (v_i & yumi_i & en_r) begin
      accum_r <= accum_r | flags_i;
    end
  end

  assign en_o          = en_r;
  assign flags_accum_o = accum_r;

endmodule

/* design/fpu_top.sv */
// ---------------------------------------------------------------------------
// fpu top: status registers beside the add/sub pipeline
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module fpu_top
  import fpu_format_pkg::*;
  import fpu_status_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  fpu_cfg_t   cfg_i,

  input  logic       v_i,
  input  fp_word_u   a_i,
  input  fp_word_u   b_i,
  input  logic       sub_i,
  output logic       ready_o,

  output logic       v_o,
  output fp_word_u   z_o,
  output fpu_flags_t flags_o,
  input  logic       yumi_i,

  output fpu_flags_t flags_accum_o
);

  logic en;

  fpu_status_regs u_status_regs (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cfg_i         (cfg_i),
    .v_i           (v_o),
    .yumi_i        (yumi_i),
    .flags_i       (flags_o),
    .en_o          (en),
    .flags_accum_o (flags_accum_o)
  );

  fpu_add_sub u_add_sub (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .en_i    (en),
    .v_i     (v_i),
    .a_i     (a_i),
    .b_i     (b_i),
    .sub_i   (sub_i),
    .ready_o (ready_o),
    .v_o     (v_o),
    .yumi_i  (yumi_i),
    .z_o     (z_o),
    .flags_o (flags_o)
  );

endmodule

/* project.f */
+incdir+design
design/fpu_format_pkg.sv
design/fpu_status_pkg.sv
design/fpu_classify.sv
design/fpu_leading_zeros.sv
design/fpu_add_sub.sv
design/fpu_status_regs.sv
design/fpu_top.sv
testbench/tb_clock.sv
testbench/tb_fpu_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator; exit status follows the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_fpu_top -o tb_fpu_top \
  && ./obj_dir/tb_fpu_top > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation PASSED"; exit 0; }

/* testbench/tb_clock.sv */
// ---------------------------------------------------------------------------
// testbench clock (10 ns) and reset held for the first 10 cycles
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release away from the active edge
  initial begin
    reset_o = 1'b1;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

/* testbench/tb_fpu_top.sv */
// ---------------------------------------------------------------------------
// directed tests for the fpu add/sub top level, check task, watchdog
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_fpu_top
  import fpu_status_pkg::*;
();

  localparam logic [3:0] FLAG_NONE      = 4'b0000;
  localparam logic [3:0] FLAG_INVALID   = 4'b1000;
  localparam logic [3:0] FLAG_OVERFLOW  = 4'b0100;
  localparam logic [3:0] FLAG_UNDERFLOW = 4'b0010;
  localparam logic [3:0] FLAG_UNIMPL    = 4'b0001;
  localparam logic [31:0] QNAN    = 32'h7FC0_0000;
  localparam logic [31:0] SNAN_RES = 32'h7FC0_0001;
  localparam logic [31:0] POS_INF = 32'h7F80_0000;

  // total operations issued, and a generous cycle bound for each
  localparam int NUM_OPS       = 100;
  localparam int CYCLES_PER_OP = 20;
  localparam int TIMEOUT_NS    = (NUM_OPS * CYCLES_PER_OP + 200) * 10;

  logic        clk_i, reset_i;
  fpu_cfg_t    cfg_i;
  logic        v_i, sub_i, ready_o, v_o, yumi_i;
  logic [31:0] a_i, b_i, z_o;
  logic [3:0]  flags_o, flags_accum_o;

  int          seed;
  int          checks, errors;
  logic [3:0]  accum_exp;
  logic [31:0] op_a_q[$], op_b_q[$], exp_z_q[$];
  logic        op_sub_q[$];
  logic [3:0]  exp_flags_q[$];

  tb_clock u_clock (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  fpu_top UUT (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cfg_i         (cfg_i),
    .v_i           (v_i),
    .a_i           (a_i),
    .b_i           (b_i),
    .sub_i         (sub_i),
    .ready_o       (ready_o),
    .v_o           (v_o),
    .z_o           (z_o),
    .flags_o       (flags_o),
    .yumi_i        (yumi_i),
    .flags_accum_o (flags_accum_o)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // exact single precision bits of an integer below 2^22 in magnitude
  function automatic logic [31:0] int_to_float(input int value);
    logic        sign;
    logic [31:0] mag;
    int          msb;
    sign = value < 0;
    mag  = sign ? -value : value;
    msb  = 0;
    for (int i = 0; i < 23; i++) begin
      if (mag[i]) begin
        msb = i;
      end
    end
    if (mag == 0) begin
      return 32'h0;
    end
    return {sign, 8'(127 + msb), 23'(mag << (23 - msb))};
  endfunction

  task automatic queue_op(input logic [31:0] a, input logic [31:0] b, input logic sub,
                          input logic [31:0] z, input logic [3:0] flags);
    op_a_q.push_back(a);
    op_b_q.push_back(b);
    op_sub_q.push_back(sub);
    exp_z_q.push_back(z);
    exp_flags_q.push_back(flags);
  endtask

  // streams the queued ops, collects in order; hold keeps yumi low that long
  task automatic run_ops(input string name, input int hold);
    int total, issued, collected, held;
    total     = exp_z_q.size();
    issued    = 0;
    collected = 0;
    held      = 0;
    while (collected < total) begin
      @(negedge clk_i);
      v_i = issued < total;
      if (issued < total) begin
        a_i   = op_a_q[issued];
        b_i   = op_b_q[issued];
        sub_i = op_sub_q[issued];
      end
      if ((v_o || held > 0) && held < hold) begin
        yumi_i = 1'b0;
        held++;
        #1;
        check_value({name, " stalled v_o"}, 1, v_o);
        check_value({name, " stalled ready_o"}, 0, ready_o);
        check_value({name, " stalled z_o"}, exp_z_q[collected], z_o);
      end else begin
        yumi_i = v_o;
        if (v_o) begin
          check_value({name, " z_o"}, exp_z_q[collected], z_o);
          check_value({name, " flags_o"}, exp_flags_q[collected], flags_o);
          accum_exp |= exp_flags_q[collected];
          collected++;
        end
        #1;
      end
      if (v_i && ready_o) begin
        issued++;
      end
    end
    @(negedge clk_i);
    v_i    = 1'b0;
    yumi_i = 1'b0;
    op_a_q.delete();
    op_b_q.delete();
    op_sub_q.delete();
    exp_z_q.delete();
    exp_flags_q.delete();
  endtask

  task automatic collect_one(input string name, input logic [31:0] exp_z,
                             input logic [3:0] exp_flags);
    @(negedge clk_i);
    while (!v_o) begin
      @(negedge clk_i);
    end
    yumi_i = 1'b1;
    check_value({name, " z_o"}, exp_z, z_o);
    check_value({name, " flags_o"}, exp_flags, flags_o);
    accum_exp |= exp_flags;
    @(negedge clk_i);
    yumi_i = 1'b0;
  endtask

  task automatic exact_test();
    int x, y;
    queue_op(32'h3FC0_0000, 32'h4010_0000, 1'b0, 32'h4070_0000, FLAG_NONE);
    queue_op(int_to_float(3), int_to_float(5), 1'b1, int_to_float(-2), FLAG_NONE);
    queue_op(int_to_float(-4), int_to_float(-4), 1'b0, int_to_float(-8), FLAG_NONE);
    run_ops("exact directed", 0);
    for (int i = 0; i < 40; i++) begin
      x = $random(seed) % (1 << 21);
      y = $random(seed) % (1 << 21);
      queue_op(int_to_float(x), int_to_float(y), 1'b0, int_to_float(x + y), FLAG_NONE);
      queue_op(int_to_float(x), int_to_float(y), 1'b1, int_to_float(x - y), FLAG_NONE);
    end
    run_ops("exact random", 0);
    check_value("exact accum", accum_exp, flags_accum_o);
  endtask

  task automatic rounding_test();
    // half ulp ties to even, 1.5 ulp rounds up to 2 ulp
    queue_op(32'h3F80_0000, 32'h3380_0000, 1'b0, 32'h3F80_0000, FLAG_NONE);
    queue_op(32'h3F80_0000, 32'h3440_0000, 1'b0, 32'h3F80_0002, FLAG_NONE);
    queue_op(32'h3F80_0000, 32'h3F7F_FFFF, 1'b1, 32'h3380_0000, FLAG_NONE);
    queue_op(int_to_float(5), int_to_float(5), 1'b1, 32'h0, FLAG_NONE);
    run_ops("rounding", 0);
  endtask

  task automatic special_test();
    queue_op(QNAN, 32'h3F80_0000, 1'b0, QNAN, FLAG_NONE);
    queue_op(32'h7F80_0001, 32'h3F80_0000, 1'b0, SNAN_RES, FLAG_INVALID);
    queue_op(POS_INF, POS_INF, 1'b1, QNAN, FLAG_INVALID);
    queue_op(POS_INF, POS_INF, 1'b0, POS_INF, FLAG_NONE);
    queue_op(POS_INF, 32'h3F80_0000, 1'b0, POS_INF, FLAG_NONE);
    queue_op(32'h0000_0001, 32'h3F80_0000, 1'b0, QNAN, FLAG_UNIMPL);
    run_ops("special", 0);
    check_value("special accum", accum_exp, flags_accum_o);
  endtask

  task automatic range_test();
    queue_op(32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0, POS_INF, FLAG_OVERFLOW);
    // difference is negative and below the normal range
    queue_op(32'h0080_0000, 32'h0080_0001, 1'b1, 32'h8000_0000, FLAG_UNDERFLOW);
    run_ops("range", 0);
    check_value("range accum", accum_exp, flags_accum_o);
  endtask

  task automatic backpressure_test();
    queue_op(int_to_float(1), int_to_float(2), 1'b0, int_to_float(3), FLAG_NONE);
    queue_op(int_to_float(10), int_to_float(4), 1'b1, int_to_float(6), FLAG_NONE);
    queue_op(int_to_float(-7), int_to_float(-1), 1'b0, int_to_float(-8), FLAG_NONE);
    run_ops("backpressure", 10);
  endtask

  task automatic config_test();
    @(negedge clk_i);
    a_i   = int_to_float(20);
    b_i   = int_to_float(22);
    sub_i = 1'b0;
    v_i   = 1'b1;
    #1;
    check_value("config accept ready_o", 1, ready_o);
    @(negedge clk_i);
    v_i          = 1'b0;
    cfg_i.we     = 1'b1;
    cfg_i.enable = 1'b0;
    @(negedge clk_i);
    cfg_i = '0;
    // pending op must sit inside the pipeline
    repeat (8) begin
      check_value("config disabled ready_o", 0, ready_o);
      check_value("config disabled v_o", 0, v_o);
      @(negedge clk_i);
    end
    cfg_i.we     = 1'b1;
    cfg_i.enable = 1'b1;
    @(negedge clk_i);
    cfg_i = '0;
    collect_one("config resume", int_to_float(42), FLAG_NONE);
    check_value("config accum", accum_exp, flags_accum_o);
    cfg_i.clear_flags = 1'b1;
    @(negedge clk_i);
    cfg_i     = '0;
    accum_exp = FLAG_NONE;
    check_value("config cleared accum", accum_exp, flags_accum_o);
    queue_op(32'h7F80_0001, 32'h3F80_0000, 1'b0, SNAN_RES, FLAG_INVALID);
    run_ops("config after clear", 0);
    check_value("config accum after clear", accum_exp, flags_accum_o);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
    $display("Checks failed");
    $finish;
  end

  initial begin
    seed      = 60665;
    checks    = 0;
    errors    = 0;
    accum_exp = FLAG_NONE;
    cfg_i     = '0;
    v_i       = 1'b0;
    a_i       = '0;
    b_i       = '0;
    sub_i     = 1'b0;
    yumi_i    = 1'b0;
    @(negedge clk_i);
    while (reset_i) begin
      @(negedge clk_i);
    end
    check_value("reset v_o", 0, v_o);
    check_value("reset ready_o", 1, ready_o);
    check_value("reset accum", 0, flags_accum_o);
    exact_test();
    rounding_test();
    special_test();
    range_test();
    backpressure_test();
    config_test();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
